//--- router_cfg_pkg.sv
package router_cfg_pkg;

    // --------------------------------------------------
    // port count of a 2D mesh router
    // --------------------------------------------------

    // five ports, one local and four mesh neighbours
    localparam int P = 5;

    // self loops are disabled, so every input can reach only P-1 outputs
    localparam int P_1 = P - 1;

    // --------------------------------------------------
    // port and coordinate types
    // --------------------------------------------------

    // port index in the usual mesh order
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_num_t;

    // x or y position of a router in the mesh
    typedef logic [3:0] coord_t;

    // one bit per router port
    typedef logic [P-1:0] port_onehot_t;

    // grant vector of one input with its own port squeezed out
    typedef logic [P_1-1:0] port_sel_t;

    // binary select of a P_1 input multiplexer
    typedef logic [1:0] port_bin_t;

endpackage

//--- flit_pkg.sv
package flit_pkg;

    import router_cfg_pkg::*;

    // a single-flit packet is one 32 bit word
    localparam int FLIT_W = 32;

    typedef logic [FLIT_W-1:0] flit_t;

    // everything below the destination field is payload
    typedef logic [23:0] payload_t;

    // --------------------------------------------------
    // field layout
    // --------------------------------------------------

    // destination x sits in the top nibble and destination y just below it
    localparam int DST_X_LSB = 28;
    localparam int DST_Y_LSB = 24;

    function automatic coord_t flit_dst_x(input flit_t f);
        return f[DST_X_LSB +: $bits(coord_t)];
    endfunction

    function automatic coord_t flit_dst_y(input flit_t f);
        return f[DST_Y_LSB +: $bits(coord_t)];
    endfunction

    function automatic payload_t flit_payload(input flit_t f);
        return f[$bits(payload_t)-1:0];
    endfunction

    // packs destination and payload into one flit, mostly for stimulus
    function automatic flit_t make_flit(input coord_t x, input coord_t y, input payload_t pl);
        return {x, y, pl};
    endfunction

endpackage

//--- switch_if.sv
interface switch_if;

    import router_cfg_pkg::*;
    import flit_pkg::*;

    // each array is indexed by input port

    // the input FIFO holds at least one flit
    logic head_valid [P];

    // one-hot output wanted by the head flit
    port_onehot_t req_port [P];

    // the head flit itself, moved by the crossbar once granted
    flit_t head_flit [P];

    // compressed grant, bit k means output k below the input index and k+1 above it
    port_sel_t granted_dest_port [P];

    modport inport (
        output head_valid,
        output req_port,
        output head_flit,
        input  granted_dest_port
    );

    modport alloc (
        input  head_valid,
        input  req_port,
        output granted_dest_port
    );

    modport xbar (
        input head_flit,
        input granted_dest_port
    );

endinterface

//--- input_port.sv
module input_port #(
    parameter router_cfg_pkg::coord_t    ROUTER_X   = 4'd0,
    parameter router_cfg_pkg::coord_t    ROUTER_Y   = 4'd0,
    parameter int                        FIFO_DEPTH = 4,
    parameter router_cfg_pkg::port_num_t SW_LOC     = router_cfg_pkg::LOCAL
) (
    input  logic            clk,
    input  logic            rst,
    input  flit_pkg::flit_t flit_in,
    input  logic            flit_in_wr,
    output logic            in_full,
    switch_if.inport        sw
);

    import router_cfg_pkg::*;
    import flit_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    flit_t            fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             fifo_wr;
    logic             fifo_rd;
    logic             fifo_empty;
    coord_t           dst_x;
    coord_t           dst_y;
    port_num_t        route;
    logic             head_ready;
    port_num_t        route_q;

    // pointers wrap at FIFO_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // --------------------------------------------------
    // flit FIFO
    // --------------------------------------------------

    // the sender honours in_full, the extra term only keeps the FIFO safe
    assign fifo_wr    = flit_in_wr & ~in_full;
    // any grant bit means the crossbar takes the head flit at this edge
    assign fifo_rd    = |sw.granted_dest_port[SW_LOC];
    assign fifo_empty = (count == '0);
    assign in_full    = (count == CNT_W'(FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            fifo_mem[wr_ptr] <= flit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (fifo_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // occupancy moves only when exactly one side is active
            case ({fifo_wr, fifo_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------------------------------------
    // XY route of the head flit
    // --------------------------------------------------

    assign dst_x = flit_dst_x(fifo_mem[rd_ptr]);
    assign dst_y = flit_dst_y(fifo_mem[rd_ptr]);

    // x is resolved first, then y, and a match on both ends at the local port
    always_comb begin
        if (dst_x > ROUTER_X) begin
            route = EAST;
        end else if (dst_x < ROUTER_X) begin
            route = WEST;
        end else if (dst_y > ROUTER_Y) begin
            route = SOUTH;
        end else if (dst_y < ROUTER_Y) begin
            route = NORTH;
        end else begin
            route = LOCAL;
        end
    end

    // the route is registered, so a new head requests one cycle after it arrives
    // and a head that leaves at this edge hands over to the next one unrouted
    always_ff @(posedge clk) begin
        if (rst) begin
            head_ready <= 1'b0;
            route_q    <= LOCAL;
        end else begin
            head_ready <= ~fifo_empty & ~fifo_rd;
            route_q    <= route;
        end
    end

    assign sw.head_valid[SW_LOC] = head_ready;
    assign sw.req_port[SW_LOC]   = port_onehot_t'(1) << route_q;
    assign sw.head_flit[SW_LOC]  = fifo_mem[rd_ptr];

    // the upstream sender must never write into a full FIFO
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        flit_in_wr |-> !in_full);

    // a flit never turns back to the port it came from
    a_no_self_route: assert property (@(posedge clk) disable iff (rst)
        sw.head_valid[SW_LOC] |-> route_q != SW_LOC);

endmodule

//--- switch_allocator.sv
module switch_allocator (
    input logic     clk,
    input logic     rst,
    switch_if.alloc sw
);

    import router_cfg_pkg::*;

    // out_req[i][j] is set when input j holds a valid head for output i
    logic [P-1:0] out_req [P];
    logic [P-1:0] out_gnt [P];
    port_num_t    win_idx [P];
    port_num_t    rr_ptr  [P];

    // grants read back from the interface, gnt_exp per input and gnt_col per output
    logic [P-1:0] gnt_exp [P];
    logic [P-1:0] gnt_col [P];

    // --------------------------------------------------
    // request matrix
    // --------------------------------------------------

    // the diagonal is masked since an input cannot be granted its own port
    always_comb begin
        for (int i = 0; i < P; i++) begin
            for (int j = 0; j < P; j++) begin
                out_req[i][j] = (i != j) && sw.head_valid[j] && sw.req_port[j][i];
            end
        end
    end

    // --------------------------------------------------
    // round-robin arbiter per output
    // --------------------------------------------------

    // the search starts at the pointer and takes the first requester it meets
    always_comb begin
        int   idx;
        logic found;
        for (int i = 0; i < P; i++) begin
            out_gnt[i] = '0;
            win_idx[i] = LOCAL;
            found      = 1'b0;
            for (int n = 0; n < P; n++) begin
                idx = (int'(rr_ptr[i]) + n) % P;
                if (!found && out_req[i][idx]) begin
                    out_gnt[i][idx] = 1'b1;
                    win_idx[i]      = port_num_t'(idx);
                    found           = 1'b1;
                end
            end
        end
    end

    // after a grant the winner drops to lowest priority on that output
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < P; i++) begin
                rr_ptr[i] <= LOCAL;
            end
        end else begin
            for (int i = 0; i < P; i++) begin
                if (|out_gnt[i]) begin
                    rr_ptr[i] <= port_num_t'((int'(win_idx[i]) + 1) % P);
                end
            end
        end
    end

    // --------------------------------------------------
    // compressed grant per input
    // --------------------------------------------------

    // input j skips its own output, so outputs above j shift down by one bit
    always_comb begin
        for (int j = 0; j < P; j++) begin
            for (int k = 0; k < P_1; k++) begin
                sw.granted_dest_port[j][k] = (k < j) ? out_gnt[k][j] : out_gnt[k + 1][j];
            end
        end
    end

    // the compressed grants widened back to one bit per output port
    always_comb begin
        for (int j = 0; j < P; j++) begin
            for (int k = 0; k < P; k++) begin
                if (k < j) begin
                    gnt_exp[j][k] = sw.granted_dest_port[j][k];
                end else if (k > j) begin
                    gnt_exp[j][k] = sw.granted_dest_port[j][k - 1];
                end else begin
                    gnt_exp[j][k] = 1'b0;
                end
                gnt_col[k][j] = gnt_exp[j][k];
            end
        end
    end

    for (genvar g = 0; g < P; g++) begin : g_chk
        // one winner per output at most
        a_one_winner: assert property (@(posedge clk) disable iff (rst)
            $onehot0(gnt_col[g]));
        // an input is granted only its requested output and only with a valid head
        a_valid_req: assert property (@(posedge clk) disable iff (rst)
            (|gnt_exp[g]) |-> (sw.head_valid[g] && (gnt_exp[g] == sw.req_port[g])));
    end

endmodule

//--- crossbar.sv
module crossbar (
    input  logic                                 clk,
    input  logic                                 rst,
    switch_if.xbar                               sw,
    output flit_pkg::flit_t                      flit_out [router_cfg_pkg::P],
    output logic [router_cfg_pkg::P-1:0]         flit_out_wr
);

    import router_cfg_pkg::*;
    import flit_pkg::*;

    // each output sees only the P_1 inputs other than itself
    flit_t        mux_in      [P][P_1];
    port_sel_t    mux_sel     [P];
    port_bin_t    mux_sel_bin [P];
    flit_t        mux_out     [P];
    port_onehot_t wr_gen      [P];
    port_onehot_t wr_or;

    // puts the sender's own position back as a zero bit
    function automatic port_onehot_t expand_grant(input port_sel_t g, input int loc);
        port_onehot_t e;
        e = '0;
        for (int k = 0; k < P; k++) begin
            if (k < loc) begin
                e[k] = g[k];
            end else if (k > loc) begin
                e[k] = g[k - 1];
            end
        end
        return e;
    endfunction

    // --------------------------------------------------
    // candidate lists and select bits
    // --------------------------------------------------

    // inputs below the output keep their slot, inputs above move down by one
    always_comb begin
        mux_in  = '{default: '0};
        mux_sel = '{default: '0};
        for (int i = 0; i < P; i++) begin
            for (int j = 0; j < P; j++) begin
                if (j < i) begin
                    mux_in[i][j]  = sw.head_flit[j];
                    mux_sel[i][j] = sw.granted_dest_port[j][i - 1];
                end else if (j > i) begin
                    mux_in[i][j - 1]  = sw.head_flit[j];
                    mux_sel[i][j - 1] = sw.granted_dest_port[j][i];
                end
            end
        end
    end

    // --------------------------------------------------
    // binary multiplexers
    // --------------------------------------------------

    // a one-hot select converts to binary by ORing the indexes of set bits
    always_comb begin
        for (int i = 0; i < P; i++) begin
            mux_sel_bin[i] = '0;
            for (int k = 0; k < P_1; k++) begin
                if (mux_sel[i][k]) begin
                    mux_sel_bin[i] = mux_sel_bin[i] | port_bin_t'(k);
                end
            end
            mux_out[i] = mux_in[i][mux_sel_bin[i]];
        end
    end

    // write strobe of output k is set when any input holds a grant for it
    always_comb begin
        wr_or = '0;
        for (int j = 0; j < P; j++) begin
            wr_gen[j] = expand_grant(sw.granted_dest_port[j], j);
            wr_or     = wr_or | wr_gen[j];
        end
    end

    // output registers load together with the FIFO pop in the input port
    always_ff @(posedge clk) begin
        for (int i = 0; i < P; i++) begin
            if (wr_or[i]) begin
                flit_out[i] <= mux_out[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flit_out_wr <= '0;
        end else begin
            flit_out_wr <= wr_or;
        end
    end

    // the allocator never lets two inputs drive one output
    for (genvar g = 0; g < P; g++) begin : g_chk
        a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
            $onehot0(mux_sel[g]));
    end

endmodule

//--- router_top.sv
module router_top #(
    parameter router_cfg_pkg::coord_t ROUTER_X   = 4'd0,
    parameter router_cfg_pkg::coord_t ROUTER_Y   = 4'd0,
    parameter int                     FIFO_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  flit_pkg::flit_t              flit_in     [router_cfg_pkg::P],
    input  logic [router_cfg_pkg::P-1:0] flit_in_wr,
    output logic [router_cfg_pkg::P-1:0] in_full,
    output flit_pkg::flit_t              flit_out    [router_cfg_pkg::P],
    output logic [router_cfg_pkg::P-1:0] flit_out_wr
);

    import router_cfg_pkg::*;

    // --------------------------------------------------
    // switch stage wiring
    // --------------------------------------------------

    // shared request, flit and grant lines between the three blocks
    switch_if sw_bus ();

    // one FIFO and route stage per port, each told its own index
    for (genvar i = 0; i < P; i++) begin : g_in
        input_port #(
            .ROUTER_X   (ROUTER_X),
            .ROUTER_Y   (ROUTER_Y),
            .FIFO_DEPTH (FIFO_DEPTH),
            .SW_LOC     (port_num_t'(i))
        ) u_input_port (
            .clk        (clk),
            .rst        (rst),
            .flit_in    (flit_in[i]),
            .flit_in_wr (flit_in_wr[i]),
            .in_full    (in_full[i]),
            .sw         (sw_bus.inport)
        );
    end

    // round-robin grant of every output to one of the other inputs
    switch_allocator u_switch_allocator (
        .clk (clk),
        .rst (rst),
        .sw  (sw_bus.alloc)
    );

    // moves granted head flits and registers them with their strobes
    crossbar u_crossbar (
        .clk         (clk),
        .rst         (rst),
        .sw          (sw_bus.xbar),
        .flit_out    (flit_out),
        .flit_out_wr (flit_out_wr)
    );

endmodule

//--- tb_router.sv
module tb_router;

    import router_cfg_pkg::*;
    import flit_pkg::*;

    localparam coord_t RX         = 4'd2;
    localparam coord_t RY         = 4'd2;
    localparam int     FIFO_DEPTH = 4;

    // traffic modes of the stimulus step
    localparam int IDLE           = 0;
    localparam int RANDOM_TRAFFIC = 1;
    localparam int LOCAL_FLOOD    = 2;

    logic         clk;
    logic         rst;
    flit_t        flit_in     [P];
    logic [P-1:0] flit_in_wr;
    logic [P-1:0] in_full;
    flit_t        flit_out    [P];
    logic [P-1:0] flit_out_wr;

    int seed = 19402;
    int errors;
    int checks;
    int strobes;

    // expected flits per source and output, in write order
    flit_t model_q [P][P][$];
    int    seq      [P];
    int    last_seq [P][P];
    int    issued   [P];
    int    accepted [P];
    int    popped   [P];

    logic [P-1:0] seen_full;
    logic         track_local;
    int           local_src [$];

    router_top #(
        .ROUTER_X   (RX),
        .ROUTER_Y   (RY),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .flit_in     (flit_in),
        .flit_in_wr  (flit_in_wr),
        .in_full     (in_full),
        .flit_out    (flit_out),
        .flit_out_wr (flit_out_wr)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // reference rules
    // --------------------------------------------------

    // dimension order routing, x first and then y
    function automatic int xy_route(input coord_t x, input coord_t y);
        if (x > RX) return int'(EAST);
        if (x < RX) return int'(WEST);
        if (y > RY) return int'(SOUTH);
        if (y < RY) return int'(NORTH);
        return int'(LOCAL);
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // destinations are kept so that no flit routes back to the port it entered
    task automatic pick_dest(input int src, output coord_t x, output coord_t y);
        x = 4'(rand_below(5));
        y = 4'(rand_below(5));
        case (src)
            1: x = 4'(rand_below(3));
            2: begin
                x = RX;
                y = 4'(2 + rand_below(3));
            end
            3: x = 4'(2 + rand_below(3));
            4: begin
                x = RX;
                y = 4'(rand_below(3));
            end
            default: if (x == RX && y == RY) y = 4'd0;
        endcase
    endtask

    // drives one flit with its source and sequence number in the payload
    task automatic issue(input int i, input coord_t x, input coord_t y);
        payload_t pl;
        flit_t    f;
        pl = {3'(i), 21'(seq[i])};
        f  = {x, y, pl};
        seq[i]++;
        issued[i]++;
        model_q[i][xy_route(x, y)].push_back(f);
        flit_in[i]    <= f;
        flit_in_wr[i] <= 1'b1;
    endtask

    // one clock of stimulus; a write is sampled by the DUT one edge later, so
    // the count of flits not yet seen at an output bounds the FIFO occupancy
    task automatic step(input int mode);
        coord_t x;
        coord_t y;
        @(posedge clk);
        for (int i = 0; i < P; i++) begin
            flit_in_wr[i] <= 1'b0;
            if (issued[i] - popped[i] < FIFO_DEPTH) begin
                if (mode == RANDOM_TRAFFIC && rand_below(2) == 0) begin
                    pick_dest(i, x, y);
                    issue(i, x, y);
                end else if (mode == LOCAL_FLOOD && i != int'(LOCAL)) begin
                    issue(i, RX, RY);
                end
            end
        end
    endtask

    // waits until the outputs have been quiet for 200 cycles
    task automatic drain();
        int idle;
        int n;
        @(posedge clk);
        flit_in_wr <= '0;
        idle = 0;
        n    = 0;
        while (idle < 200 && n < 5000) begin
            @(negedge clk);
            n++;
            if (flit_out_wr != '0) idle = 0;
            else idle++;
        end
        if (idle < 200) begin
            errors++;
            $display("outputs kept writing for %0d cycles and never went idle", n);
        end
    endtask

    // compares one output strobe with the head of its source queue
    task automatic check_output(input int k);
        flit_t f;
        flit_t exp_f;
        int    src;
        int    rt;
        f   = flit_out[k];
        src = int'(f[23:21]);
        rt  = xy_route(f[31:28], f[27:24]);
        strobes++;
        checks++;
        if (rt != k) begin
            errors++;
            $display("Mismatch at time %0t: flit_out[%0d] route expected %0d, actual %0d",
                     $time, k, k, rt);
        end
        if (src >= P) begin
            errors++;
            $display("flit %h on output %0d names no valid source port", f, k);
        end else if (model_q[src][k].size() == 0) begin
            errors++;
            popped[src]++;
            $display("output %0d wrote flit %h but input %0d had nothing queued for it",
                     k, f, src);
        end else begin
            popped[src]++;
            if (track_local && k == int'(LOCAL)) local_src.push_back(src);
            exp_f = model_q[src][k].pop_front();
            if (f !== exp_f) begin
                errors++;
                $display("Mismatch at time %0t: flit_out[%0d] expected %h, actual %h",
                         $time, k, exp_f, f);
            end
            // sequence numbers of one source only grow
            if (int'(f[20:0]) <= last_seq[src][k]) begin
                errors++;
                $display("Mismatch at time %0t: flit_out[%0d] sequence expected > %0d, actual %0d",
                         $time, k, last_seq[src][k], int'(f[20:0]));
            end
            last_seq[src][k] = int'(f[20:0]);
        end
    endtask

    // --------------------------------------------------
    // output monitor and in_full model
    // --------------------------------------------------

    // sampled at the falling edge, halfway between DUT updates
    always @(negedge clk) begin
        logic exp_full;
        if (!rst) begin
            for (int k = 0; k < P; k++) begin
                if (flit_out_wr[k]) check_output(k);
            end
            // full exactly when FIFO_DEPTH accepted flits have not been popped
            for (int i = 0; i < P; i++) begin
                exp_full = (accepted[i] - popped[i]) >= FIFO_DEPTH;
                checks++;
                if (in_full[i] !== exp_full) begin
                    errors++;
                    $display("Mismatch at time %0t: in_full[%0d] expected %0b, actual %0b",
                             $time, i, exp_full, in_full[i]);
                end
                if (in_full[i]) seen_full[i] = 1'b1;
            end
        end
    end

    // writes are counted at the edge where the DUT samples them
    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < P; i++) begin
                if (flit_in_wr[i]) accepted[i]++;
            end
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial begin
        logic [P-1:0] mask;
        int           n;
        int           total;
        clk         = 1'b0;
        rst         = 1'b1;
        flit_in_wr  = '0;
        flit_in     = '{default: '0};
        errors      = 0;
        checks      = 0;
        strobes     = 0;
        seen_full   = '0;
        track_local = 1'b0;
        for (int i = 0; i < P; i++) begin
            seq[i]      = 0;
            issued[i]   = 0;
            accepted[i] = 0;
            popped[i]   = 0;
            for (int k = 0; k < P; k++) last_seq[i][k] = -1;
        end

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        if (flit_out_wr !== '0 || in_full !== '0) begin
            errors++;
            $display("Mismatch at time %0t: flit_out_wr and in_full expected 0, actual %b %b",
                     $time, flit_out_wr, in_full);
        end

        // random legal traffic on all five inputs
        repeat (400) step(RANDOM_TRAFFIC);
        drain();

        // a lone flit from EAST to LOCAL through an idle router
        @(posedge clk);
        issue(int'(EAST), RX, RY);
        @(posedge clk);
        flit_in_wr[EAST] <= 1'b0;
        n = 0;
        while (n < 20) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (flit_out_wr[LOCAL]) break;
        end
        checks++;
        if (!flit_out_wr[LOCAL]) begin
            errors++;
            $display("the single EAST flit never reached the LOCAL output");
        end else if (n != 2) begin
            errors++;
            $display("Mismatch at time %0t: flit_out_wr latency expected 2, actual %0d", $time, n);
        end
        drain();

        // four neighbours flood LOCAL until each of them has filled its FIFO
        seen_full = '0;
        n = 0;
        step(LOCAL_FLOOD);
        while (n < 200 && seen_full[4:1] != 4'hf) begin
            step(LOCAL_FLOOD);
            n++;
        end
        checks++;
        if (seen_full[4:1] != 4'hf) begin
            errors++;
            $display("in_full never rose on every neighbour input while they flooded LOCAL");
        end

        // every four LOCAL outputs in a row come from four different inputs
        local_src.delete();
        step(LOCAL_FLOOD);
        track_local = 1'b1;
        n = 0;
        while (n < 400 && local_src.size() < 40) begin
            step(LOCAL_FLOOD);
            n++;
        end
        track_local = 1'b0;
        if (local_src.size() < 40) begin
            errors++;
            $display("only %0d LOCAL outputs seen while four inputs flooded it", local_src.size());
        end
        for (int w = 0; w + 4 <= local_src.size(); w++) begin
            mask = '0;
            for (int m = 0; m < 4; m++) mask[local_src[w + m]] = 1'b1;
            checks++;
            if (mask != 5'b11110) begin
                errors++;
                $display("LOCAL outputs %0d to %0d came from sources %b, not one from each neighbour",
                         w, w + 3, mask);
            end
        end
        drain();

        // nothing may stay behind and nothing may appear twice
        total = 0;
        for (int i = 0; i < P; i++) begin
            total += accepted[i];
            for (int k = 0; k < P; k++) begin
                checks++;
                if (model_q[i][k].size() != 0) begin
                    errors++;
                    $display("%0d flits from input %0d to output %0d never left the router",
                             model_q[i][k].size(), i, k);
                end
            end
        end
        checks++;
        if (strobes != total) begin
            errors++;
            $display("%0d output writes seen for %0d accepted input writes", strobes, total);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- compile.f
router_cfg_pkg.sv
flit_pkg.sv
switch_if.sv
input_port.sv
switch_allocator.sv
crossbar.sv
router_top.sv
tb_router.sv
